//--- Makefile
VERILATOR  := verilator
TOP        := regfile_alu_tb
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
SIM_FLAGS  := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- source/alu_exec.sv
// Execute stage; picks forwarded or stored operands and applies the opcode
`timescale 1ns/1ps

module alu_exec (
   input  logic                   exec_v_i,
   input  regfile_pkg::exec_s     exec_i,
   input  regfile_pkg::reg_addr_t rs0_i,
   input  regfile_pkg::reg_addr_t rs1_i,
   input  regfile_pkg::word_t     r0_data_i,
   input  regfile_pkg::word_t     r1_data_i,
   input  logic                   wb_v_i,
   input  regfile_pkg::wb_s       wb_i,
   input  logic                   prev_v_i,
   input  regfile_pkg::wb_s       prev_i,
   output logic                   alu_v_o,
   output regfile_pkg::wb_s       alu_o
);

   regfile_pkg::word_t opnd0;
   regfile_pkg::word_t opnd1;
   regfile_pkg::word_t result;

   // Newest value wins; the memory copy may be stale or mid-write
   function automatic regfile_pkg::word_t pick_operand(
      input regfile_pkg::reg_addr_t rs,
      input regfile_pkg::word_t     mem_data,
      input logic                   wb_v,
      input regfile_pkg::wb_s       wb,
      input logic                   prev_v,
      input regfile_pkg::wb_s       prev
   );
      regfile_pkg::word_t value;
      if (rs == '0)
         value = '0;  // Register 0 is hardwired
      else if (wb_v && (wb.rd == rs))
         value = wb.data;  // Being written this cycle
      else if (prev_v && (prev.rd == rs))
         value = prev.data;  // Written during our read
      else
         value = mem_data;
      pick_operand = value;
   endfunction

   always_comb
   begin
      opnd0 = pick_operand(rs0_i, r0_data_i, wb_v_i, wb_i, prev_v_i, prev_i);
      opnd1 = pick_operand(rs1_i, r1_data_i, wb_v_i, wb_i, prev_v_i, prev_i);
   end

   always_comb
   begin
      case (exec_i.op)
         regfile_pkg::OP_ADD:
            result = opnd0 + opnd1;
         regfile_pkg::OP_SUB:
            result = opnd0 - opnd1;  // Wraps
         regfile_pkg::OP_AND:
            result = opnd0 & opnd1;
         regfile_pkg::OP_OR:
            result = opnd0 | opnd1;
         regfile_pkg::OP_XOR:
            result = opnd0 ^ opnd1;
         regfile_pkg::OP_MOV:
            result = opnd0;
         regfile_pkg::OP_LI:
            result = {{(regfile_pkg::DATA_W-16){1'b0}}, exec_i.imm};
         default:
            result = '0;
      endcase
   end

   assign alu_v_o    = exec_v_i;
   assign alu_o.rd   = exec_i.rd;
   assign alu_o.data = result;

endmodule

//--- source/op_issue.sv
// Input stage; starts the operand reads and registers the operation for execute
`timescale 1ns/1ps

module op_issue (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  op_v_i,
   input  regfile_pkg::op_req_s  op_i,
   output logic                  r0_v_o,
   output logic                  r1_v_o,
   output regfile_pkg::reg_addr_t r0_addr_o,
   output regfile_pkg::reg_addr_t r1_addr_o,
   output logic                  exec_v_o,
   output regfile_pkg::exec_s    exec_o,
   output regfile_pkg::reg_addr_t exec_rs0_o,
   output regfile_pkg::reg_addr_t exec_rs1_o
);

   logic uses_rs0;
   logic uses_rs1;

   // LI needs no operand, MOV only the first
   assign uses_rs0 = (op_i.op != regfile_pkg::OP_LI);
   assign uses_rs1 = uses_rs0 && (op_i.op != regfile_pkg::OP_MOV);

   assign r0_v_o    = op_v_i && uses_rs0;
   assign r1_v_o    = op_v_i && uses_rs1;
   assign r0_addr_o = op_i.rs0;
   assign r1_addr_o = op_i.rs1;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         exec_v_o <= 1'b0;
      else
         exec_v_o <= op_v_i;
   end

   // Payload only, captured with the strobe
   always_ff @(posedge clk_i)
   begin
      if (op_v_i)
      begin
         exec_o.op  <= op_i.op;
         exec_o.rd  <= op_i.rd;
         exec_o.imm <= op_i.imm;
         exec_rs0_o <= op_i.rs0;  // Kept for the forwarding compare
         exec_rs1_o <= op_i.rs1;
      end
   end

endmodule

//--- source/reg_mem_2r1w_sync.sv
// Behavioural two-read one-write register memory with registered read ports
`timescale 1ns/1ps

module reg_mem_2r1w_sync #(
   parameter int width_p = 32,
   parameter int els_p   = 32
) (
   input  logic                       clk_i,

   input  logic                       w_v_i,
   input  logic [$clog2(els_p)-1:0]   w_addr_i,
   input  logic [width_p-1:0]         w_data_i,

   input  logic                       r0_v_i,
   input  logic [$clog2(els_p)-1:0]   r0_addr_i,
   output logic [width_p-1:0]         r0_data_o,

   input  logic                       r1_v_i,
   input  logic [$clog2(els_p)-1:0]   r1_addr_i,
   output logic [width_p-1:0]         r1_data_o
);

   logic [width_p-1:0] mem_r [els_p];

   // Write port, stored at the end of the cycle it is presented
   always_ff @(posedge clk_i)
   begin
      if (w_v_i)
      begin
         mem_r[w_addr_i] <= w_data_i;
      end
   end

   // Read port 0, output holds while not enabled
   always_ff @(posedge clk_i)
   begin
      if (r0_v_i)
      begin
         r0_data_o <= mem_r[r0_addr_i];  // Undefined if same address written
      end
   end

   // Read port 1
   always_ff @(posedge clk_i)
   begin
      if (r1_v_i)
      begin
         r1_data_o <= mem_r[r1_addr_i];
      end
   end

endmodule

//--- source/regfile_alu_top.sv
// Top level of the register-file datapath; wires issue, memory, execute and writeback
`timescale 1ns/1ps

module regfile_alu_top #(
   parameter int width_p = regfile_pkg::DATA_W,
   parameter int els_p   = regfile_pkg::REG_ELS
) (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 op_v_i,
   input  regfile_pkg::op_req_s op_i,
   output logic                 result_v_o,
   output regfile_pkg::wb_s     result_o
);

   logic                   r0_v;
   logic                   r1_v;
   regfile_pkg::reg_addr_t r0_addr;
   regfile_pkg::reg_addr_t r1_addr;
   regfile_pkg::word_t     r0_data;
   regfile_pkg::word_t     r1_data;
   logic                   exec_v;
   regfile_pkg::exec_s     exec;
   regfile_pkg::reg_addr_t exec_rs0;
   regfile_pkg::reg_addr_t exec_rs1;
   logic                   alu_v;
   regfile_pkg::wb_s       alu;
   logic                   w_v;
   regfile_pkg::reg_addr_t w_addr;
   regfile_pkg::word_t     w_data;
   logic                   wb_v;
   regfile_pkg::wb_s       wb;
   logic                   prev_v;
   regfile_pkg::wb_s       prev;

   op_issue op_issue_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .op_v_i     (op_v_i),
      .op_i       (op_i),
      .r0_v_o     (r0_v),
      .r1_v_o     (r1_v),
      .r0_addr_o  (r0_addr),
      .r1_addr_o  (r1_addr),
      .exec_v_o   (exec_v),
      .exec_o     (exec),
      .exec_rs0_o (exec_rs0),
      .exec_rs1_o (exec_rs1)
   );

   reg_mem_2r1w_sync #(
      .width_p (width_p),
      .els_p   (els_p)
   ) reg_mem_i (
      .clk_i     (clk_i),
      .w_v_i     (w_v),
      .w_addr_i  (w_addr),
      .w_data_i  (w_data),
      .r0_v_i    (r0_v),
      .r0_addr_i (r0_addr),
      .r0_data_o (r0_data),
      .r1_v_i    (r1_v),
      .r1_addr_i (r1_addr),
      .r1_data_o (r1_data)
   );

   alu_exec alu_exec_i (
      .exec_v_i  (exec_v),
      .exec_i    (exec),
      .rs0_i     (exec_rs0),
      .rs1_i     (exec_rs1),
      .r0_data_i (r0_data),
      .r1_data_i (r1_data),
      .wb_v_i    (wb_v),
      .wb_i      (wb),
      .prev_v_i  (prev_v),
      .prev_i    (prev),
      .alu_v_o   (alu_v),
      .alu_o     (alu)
   );

   result_writeback result_wb_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .alu_v_i    (alu_v),
      .alu_i      (alu),
      .w_v_o      (w_v),
      .w_addr_o   (w_addr),
      .w_data_o   (w_data),
      .wb_v_o     (wb_v),
      .wb_o       (wb),
      .prev_v_o   (prev_v),
      .prev_o     (prev),
      .result_v_o (result_v_o),
      .result_o   (result_o)
   );

endmodule

//--- source/regfile_pkg.sv
// Shared word, address, opcode and stage types for the register-file datapath
package regfile_pkg;

   localparam int DATA_W     = 32;
   localparam int REG_ELS    = 32;
   localparam int REG_ADDR_W = $clog2(REG_ELS);

   typedef logic [DATA_W-1:0]     word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // Opcode encodings, 3'd7 is unused
   typedef enum logic [2:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_OR  = 3'd3,
      OP_XOR = 3'd4,
      OP_MOV = 3'd5,  // Copies source 0
      OP_LI  = 3'd6   // Zero-extended 16-bit immediate
   } alu_op_e;

   // Operation as presented at the input
   typedef struct packed {
      alu_op_e     op;
      reg_addr_t   rd;
      reg_addr_t   rs0;
      reg_addr_t   rs1;
      logic [15:0] imm;
   } op_req_s;

   // Fields carried from issue into execute
   typedef struct packed {
      alu_op_e     op;
      reg_addr_t   rd;
      logic [15:0] imm;
   } exec_s;

   // Result entry, also the write and forwarding payload
   typedef struct packed {
      reg_addr_t rd;
      word_t     data;
   } wb_s;

endpackage

//--- source/result_writeback.sv
// Output stage; registers the result, writes it back and holds forwarding copies
`timescale 1ns/1ps

module result_writeback (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   alu_v_i,
   input  regfile_pkg::wb_s       alu_i,
   output logic                   w_v_o,
   output regfile_pkg::reg_addr_t w_addr_o,
   output regfile_pkg::word_t     w_data_o,
   output logic                   wb_v_o,
   output regfile_pkg::wb_s       wb_o,
   output logic                   prev_v_o,
   output regfile_pkg::wb_s       prev_o,
   output logic                   result_v_o,
   output regfile_pkg::wb_s       result_o
);

   logic             wb_v_r;
   regfile_pkg::wb_s wb_r;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wb_v_r   <= 1'b0;
         prev_v_o <= 1'b0;
      end
      else
      begin
         wb_v_r   <= alu_v_i;
         prev_v_o <= w_v_o;  // Previous cycle's memory write
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (alu_v_i)
         wb_r <= alu_i;
      prev_o <= wb_r;
   end

   // Writes to register 0 are dropped, the result is still reported
   assign w_v_o    = wb_v_r && (wb_r.rd != '0);
   assign w_addr_o = wb_r.rd;
   assign w_data_o = wb_r.data;

   assign wb_v_o     = wb_v_r;
   assign wb_o       = wb_r;
   assign result_v_o = wb_v_r;
   assign result_o   = wb_r;

endmodule

//--- test/regfile_alu_props.sv
// Concurrent checks on result latency and the memory write port, bound into the datapath top
`timescale 1ns/1ps

module regfile_alu_props (
   input logic                   clk_i,
   input logic                   rst_n_i,
   input logic                   op_v_i,
   input regfile_pkg::reg_addr_t op_rd_i,
   input logic                   result_v_i,
   input logic                   w_v_i,
   input regfile_pkg::reg_addr_t w_addr_i
);

   logic seen_op;  // Set by the first accepted operation
   int   prop_fails;

   initial prop_fails = 0;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         seen_op <= 1'b0;
      else if (op_v_i)
         seen_op <= 1'b1;
   end

   // Every accepted operation gives a result two edges later
   result_after_op: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(op_v_i, 2) |-> result_v_i)
   else
   begin
      $error("result_v_o missing two cycles after an accepted operation");
      prop_fails = prop_fails + 1;
   end

   // And no result without one
   op_before_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      result_v_i |-> $past(op_v_i, 2))
   else
   begin
      $error("result_v_o high without an operation two cycles before");
      prop_fails = prop_fails + 1;
   end

   // A write goes to the rd accepted two edges earlier, never to register 0
   no_write_to_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      w_v_i |-> ($past(op_v_i, 2) && ($past(op_rd_i, 2) != '0)
                 && (w_addr_i == $past(op_rd_i, 2))))
   else
   begin
      $error("Memory write to register 0 or to the wrong register");
      prop_fails = prop_fails + 1;
   end

   quiet_after_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !seen_op |-> (!result_v_i && !w_v_i))
   else
   begin
      $error("Result or write strobe active before the first operation");
      prop_fails = prop_fails + 1;
   end

endmodule

bind regfile_alu_top regfile_alu_props props_i (
   .clk_i      (clk_i),
   .rst_n_i    (rst_n_i),
   .op_v_i     (op_v_i),
   .op_rd_i    (op_i.rd),
   .result_v_i (result_v_o),
   .w_v_i      (w_v),
   .w_addr_i   (w_addr)
);

//--- test/regfile_alu_tb.sv
// Self-checking testbench for the register-file datapath, used as the simulation top
`timescale 1ns/1ps

module regfile_alu_tb;

   localparam int CLK_PERIOD_NS = 4;
   localparam int RESET_CYCLES  = 4;
   localparam int NUM_RANDOM    = 400;
   localparam int NUM_OPS       = regfile_pkg::REG_ELS + NUM_RANDOM;
   // Worst case three cycles per operation and doubled for margin
   localparam int WATCHDOG_NS   = (NUM_OPS * 3 + RESET_CYCLES + 50) * CLK_PERIOD_NS * 2;

   logic                 clk;
   logic                 rst_n;
   logic                 op_v;
   regfile_pkg::op_req_s op;
   logic                 result_v;
   regfile_pkg::wb_s     result;

   logic [31:0]          lfsr_state;
   regfile_pkg::word_t   model_regs [regfile_pkg::REG_ELS];
   regfile_pkg::wb_s     expect_q [$];
   int                   sent_cnt;
   int                   checked_cnt;
   string                phase;

   regfile_alu_top dut_i (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .op_v_i     (op_v),
      .op_i       (op),
      .result_v_o (result_v),
      .result_o   (result)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD_NS / 2) clk = ~clk;
   end

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("Something failed");
      $fatal(1, "Simulation stopped on error");
   endtask

   // Galois form with polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic [31:0] shifted;
      shifted = state >> 1;
      if (state[0])
         shifted = shifted ^ 32'h80200003;
      lfsr_next = shifted;
   endfunction

   function automatic logic [31:0] take_bits(input int count);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < count; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         value      = {value[30:0], lfsr_state[0]};
      end
      take_bits = value;
   endfunction

   // Reference result from the register model
   function automatic regfile_pkg::word_t expected_data(input regfile_pkg::op_req_s req);
      regfile_pkg::word_t src_a;
      regfile_pkg::word_t src_b;
      regfile_pkg::word_t data;
      src_a = model_regs[req.rs0];
      src_b = model_regs[req.rs1];
      case (req.op)
         regfile_pkg::OP_ADD: data = src_a + src_b;
         regfile_pkg::OP_SUB: data = src_a - src_b;
         regfile_pkg::OP_AND: data = src_a & src_b;
         regfile_pkg::OP_OR:  data = src_a | src_b;
         regfile_pkg::OP_XOR: data = src_a ^ src_b;
         regfile_pkg::OP_MOV: data = src_a;
         regfile_pkg::OP_LI:  data = {16'h0000, req.imm};
         default:             data = '0;
      endcase
      expected_data = data;
   endfunction

   function automatic regfile_pkg::op_req_s random_op(input regfile_pkg::reg_addr_t last_rd,
                                                      input regfile_pkg::reg_addr_t older_rd);
      regfile_pkg::op_req_s req;
      logic [2:0]           code;
      code = 3'(take_bits(3));
      if (code == 3'd7)
         code = 3'd0;  // Unused encoding folded onto ADD
      req.op  = regfile_pkg::alu_op_e'(code);
      req.rd  = regfile_pkg::reg_addr_t'(take_bits(5));
      req.rs0 = regfile_pkg::reg_addr_t'(take_bits(5));
      req.rs1 = regfile_pkg::reg_addr_t'(take_bits(5));
      req.imm = 16'(take_bits(16));
      // Dependent on the last and the one before
      if (take_bits(1) == 32'd1)
         req.rs0 = last_rd;
      if (take_bits(1) == 32'd1)
         req.rs1 = older_rd;
      random_op = req;
   endfunction

   task automatic idle_cycles(input int count);
      op_v = 1'b0;
      repeat (count)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic send_op(input regfile_pkg::op_req_s req);
      regfile_pkg::wb_s entry;
      entry.rd   = req.rd;
      entry.data = expected_data(req);
      expect_q.push_back(entry);
      if (req.rd != '0)
         model_regs[req.rd] = entry.data;  // Register 0 stays zero
      sent_cnt++;
      op_v = 1'b1;
      op   = req;
      @(posedge clk);
      #1;
      op_v = 1'b0;
   endtask

   // Outputs are checked mid-cycle
   always @(negedge clk)
   begin
      props_clean: assert (dut_i.props_i.prop_fails == 0)
      else
         fail_run("A latency or write-port property of the DUT failed");
      if (rst_n && result_v)
      begin
         result_expected: assert (expect_q.size() > 0)
         else
            fail_run("A result arrived with no operation outstanding");
         result_match: assert (result == expect_q[0])
         else
         begin
            $display("** Error %s: expected rd %0d data %h, actual rd %0d data %h",
                     phase, expect_q[0].rd, expect_q[0].data, result.rd, result.data);
            fail_run("Result mismatch");
         end
         void'(expect_q.pop_front());
         checked_cnt++;
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      fail_run("Timeout: the DUT did not deliver every result in time");
   end

   initial
   begin
      regfile_pkg::op_req_s   req;
      regfile_pkg::reg_addr_t last_rd;
      regfile_pkg::reg_addr_t older_rd;
      int                     gap;
      lfsr_state  = 32'hce87fe9b;
      rst_n       = 1'b0;
      op_v        = 1'b0;
      op          = '0;
      sent_cnt    = 0;
      checked_cnt = 0;
      phase       = "reset";
      for (int r = 0; r < regfile_pkg::REG_ELS; r++)
         model_regs[r] = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      idle_cycles(3);  // Strobes must stay low here

      phase = "register load";
      for (int r = 0; r < regfile_pkg::REG_ELS; r++)
      begin
         req     = '0;
         req.op  = regfile_pkg::OP_LI;
         req.rd  = regfile_pkg::reg_addr_t'(r);
         req.imm = 16'(take_bits(16));
         send_op(req);
      end

      phase    = "random operations";
      last_rd  = '0;
      older_rd = '0;
      for (int n = 0; n < NUM_RANDOM; n++)
      begin
         req = random_op(last_rd, older_rd);
         send_op(req);
         older_rd = last_rd;
         last_rd  = req.rd;
         gap      = int'(take_bits(2));
         if (gap != 3)
            idle_cycles(gap);  // Gap of 0, 1 or 2 cycles
      end

      wait (checked_cnt == sent_cnt);
      idle_cycles(4);  // No stray results after the last one
      $display("Everything OK");
      $finish;
   end

endmodule

//--- verilog.f
source/regfile_pkg.sv
source/reg_mem_2r1w_sync.sv
source/op_issue.sv
source/alu_exec.sv
source/result_writeback.sv
source/regfile_alu_top.sv
test/regfile_alu_props.sv
test/regfile_alu_tb.sv
